/* source/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // Word address, byte address bits 27 down to 2
  typedef logic [25:0] word_addr_t;

  typedef logic [31:0] bus_data_t;

  // Set bit writes that byte lane
  typedef logic [3:0] byte_mask_t;

  // Top four bits of a word address
  typedef logic [3:0] region_t;

  localparam region_t REGION_ROM = 4'd0;
  localparam region_t REGION_RAM = 4'd1;

  localparam logic CMD_READ  = 1'b0;
  localparam logic CMD_WRITE = 1'b1;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_FETCH,
    ARB_MEM
  } arb_state_t;

endpackage

`default_nettype wire

/* source/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter #(
  parameter int BURST_LEN = 4
) (
  input  logic clk_core,
  input  logic rst,
  input  logic fe_cvalid,
  input  logic ls_cvalid,
  input  logic done,
  output logic gnt_fetch,
  output logic gnt_mem
);
  import soc_bus_pkg::*;

  arb_state_t state;
  // Fetch held the most recent grant
  logic       last_fetch;
  logic       pick_fetch;

  initial begin
    if (BURST_LEN < 2 || (BURST_LEN & (BURST_LEN - 1)) != 0) begin
      $fatal(1, "BURST_LEN must be a power of two, at least 2");
    end
  end

  // On a tie the port not served last goes first
  assign pick_fetch = fe_cvalid && (!ls_cvalid || !last_fetch);

  always_ff @(posedge clk_core) begin
    if (rst) begin
      state      <= ARB_IDLE;
      last_fetch <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (pick_fetch) begin
            state      <= ARB_FETCH;
            last_fetch <= 1'b1;
          end else if (ls_cvalid) begin
            state      <= ARB_MEM;
            last_fetch <= 1'b0;
          end
        end
        ARB_FETCH, ARB_MEM: begin
          if (done) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  assign gnt_fetch = (state == ARB_FETCH);
  assign gnt_mem   = (state == ARB_MEM);

  a_gnt_onehot: assert property (@(posedge clk_core) disable iff (rst)
    !(gnt_fetch && gnt_mem));

endmodule

`default_nettype wire

/* source/bus_main.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_main (
  input  logic                    clk_core,
  input  logic                    rst,
  input  logic                    gnt_fetch,
  input  logic                    gnt_mem,
  input  logic                    fe_cvalid,
  input  soc_bus_pkg::word_addr_t fe_addr,
  input  logic                    fe_rready,
  input  logic                    fe_eack,
  input  logic                    ls_cvalid,
  input  logic                    ls_cmd,
  input  soc_bus_pkg::word_addr_t ls_addr,
  input  logic                    ls_wvalid,
  input  logic                    ls_wlast,
  input  soc_bus_pkg::bus_data_t  ls_wdata,
  input  soc_bus_pkg::byte_mask_t ls_wmask,
  input  logic                    ls_rready,
  input  logic                    ls_eack,
  input  logic                    rom_cready,
  input  logic                    rom_rvalid,
  input  logic                    rom_rlast,
  input  soc_bus_pkg::bus_data_t  rom_rdata,
  input  logic                    ram_cready,
  input  logic                    ram_wready,
  input  logic                    ram_rvalid,
  input  logic                    ram_rlast,
  input  soc_bus_pkg::bus_data_t  ram_rdata,
  output logic                    tgt_cmd,
  output soc_bus_pkg::word_addr_t tgt_addr,
  output soc_bus_pkg::bus_data_t  tgt_wdata,
  output soc_bus_pkg::byte_mask_t tgt_wmask,
  output logic                    tgt_wlast,
  output logic                    rom_cvalid,
  output logic                    rom_rready,
  output logic                    ram_cvalid,
  output logic                    ram_wvalid,
  output logic                    ram_rready,
  output logic                    fe_cready,
  output logic                    fe_rvalid,
  output logic                    fe_error,
  output logic                    ls_cready,
  output logic                    ls_wready,
  output logic                    ls_rvalid,
  output logic                    ls_error,
  output soc_bus_pkg::bus_data_t  rdata,
  output logic                    rlast,
  output logic                    done
);
  import soc_bus_pkg::*;

  logic    m_cvalid;
  logic    m_rready;
  logic    m_eack;
  region_t region;
  logic    hit_rom;
  logic    hit_ram;
  logic    cmd_phase;
  logic    c_ready;
  logic    cmd_xfer;
  logic    t_rvalid;
  logic    wr_xfer;
  // Data phase state and latched target
  logic    busy;
  logic    sel_ram;
  logic    err_level;

  // Granted initiator onto the target side
  assign m_cvalid  = (gnt_fetch && fe_cvalid) || (gnt_mem && ls_cvalid);
  assign m_rready  = (gnt_fetch && fe_rready) || (gnt_mem && ls_rready);
  assign m_eack    = (gnt_fetch && fe_eack) || (gnt_mem && ls_eack);
  assign tgt_cmd   = gnt_mem ? ls_cmd : CMD_READ;
  assign tgt_addr  = gnt_mem ? ls_addr : fe_addr;
  assign tgt_wdata = ls_wdata;
  assign tgt_wmask = ls_wmask;
  assign tgt_wlast = ls_wlast;

  // Writes to the ROM region have no target and take the error path
  assign region  = tgt_addr[25:22];
  assign hit_rom = (region == REGION_ROM) && (tgt_cmd == CMD_READ);
  assign hit_ram = (region == REGION_RAM);

  assign cmd_phase  = (gnt_fetch || gnt_mem) && !busy && !err_level;
  assign c_ready    = cmd_phase && (hit_rom ? rom_cready : (hit_ram ? ram_cready : 1'b1));
  assign cmd_xfer   = m_cvalid && c_ready;
  assign rom_cvalid = cmd_phase && m_cvalid && hit_rom;
  assign ram_cvalid = cmd_phase && m_cvalid && hit_ram;
  assign fe_cready  = gnt_fetch && c_ready;
  assign ls_cready  = gnt_mem && c_ready;

  // Return path follows the latched target
  assign t_rvalid   = busy && (sel_ram ? ram_rvalid : rom_rvalid);
  assign rdata      = sel_ram ? ram_rdata : rom_rdata;
  assign rlast      = sel_ram ? ram_rlast : rom_rlast;
  assign rom_rready = busy && !sel_ram && m_rready;
  assign ram_rready = busy && sel_ram && m_rready;
  assign fe_rvalid  = gnt_fetch && t_rvalid;
  assign ls_rvalid  = gnt_mem && t_rvalid;

  assign ram_wvalid = busy && sel_ram && gnt_mem && ls_wvalid;
  assign ls_wready  = busy && sel_ram && gnt_mem && ram_wready;
  assign wr_xfer    = ram_wvalid && ram_wready;

  assign fe_error = gnt_fetch && err_level;
  assign ls_error = gnt_mem && err_level;

  assign done = (t_rvalid && m_rready && rlast) || (wr_xfer && ls_wlast) || (err_level && m_eack);

  always_ff @(posedge clk_core) begin
    if (rst) begin
      busy      <= 1'b0;
      sel_ram   <= 1'b0;
      err_level <= 1'b0;
    end else begin
      if (cmd_xfer && (hit_rom || hit_ram)) begin
        busy    <= 1'b1;
        sel_ram <= hit_ram;
      end else if (done) begin
        busy <= 1'b0;
      end
      // Unmapped command holds error until acknowledged
      if (cmd_xfer && !hit_rom && !hit_ram) begin
        err_level <= 1'b1;
      end else if (m_eack) begin
        err_level <= 1'b0;
      end
    end
  end

  // Target beats only arrive during a latched data phase
  a_rvalid_in_phase: assert property (@(posedge clk_core) disable iff (rst)
    (rom_rvalid || ram_rvalid) |-> busy);

  // Targets stay silent while an error waits for eack
  a_err_no_rvalid: assert property (@(posedge clk_core) disable iff (rst)
    err_level |-> !(rom_rvalid || ram_rvalid));

endmodule

`default_nettype wire

/* source/boot_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module boot_rom #(
  parameter int ROM_WORDS = 64,
  parameter int BURST_LEN = 4
) (
  input  logic                    clk_core,
  input  logic                    rst,
  input  logic                    cvalid,
  input  soc_bus_pkg::word_addr_t addr,
  input  logic                    rready,
  output logic                    cready,
  output logic                    rvalid,
  output logic                    rlast,
  output soc_bus_pkg::bus_data_t  rdata
);
  import soc_bus_pkg::*;

  localparam int IDX_W  = $clog2(ROM_WORDS);
  localparam int BEAT_W = $clog2(BURST_LEN);

  bus_data_t         mem [ROM_WORDS];
  logic [IDX_W-1:0]  ptr;
  logic [IDX_W-1:0]  ptr_next;
  logic [IDX_W-1:0]  start;
  logic [BEAT_W-1:0] beat;
  logic              cmd_xfer;
  logic              beat_xfer;

  initial begin
    $readmemh("rom.hex", mem);
  end

  assign cready    = !rvalid;
  assign cmd_xfer  = cvalid && cready;
  assign beat_xfer = rvalid && rready;
  // Aligned burst start, wrapped to the ROM size
  assign start     = {addr[IDX_W-1:BEAT_W], {BEAT_W{1'b0}}};
  assign ptr_next  = ptr + IDX_W'(1);

  always_ff @(posedge clk_core) begin
    if (rst) begin
      rvalid <= 1'b0;
      rlast  <= 1'b0;
      beat   <= '0;
    end else if (cmd_xfer) begin
      rvalid <= 1'b1;
      rlast  <= 1'b0;
      beat   <= '0;
    end else if (beat_xfer) begin
      rvalid <= !rlast;
      rlast  <= (beat == BEAT_W'(BURST_LEN - 2));
      beat   <= beat + BEAT_W'(1);
    end
  end

  // Next word fetched as each beat is taken
  always_ff @(posedge clk_core) begin
    if (cmd_xfer) begin
      ptr   <= start;
      rdata <= mem[start];
    end else if (beat_xfer && !rlast) begin
      ptr   <= ptr_next;
      rdata <= mem[ptr_next];
    end
  end

endmodule

`default_nettype wire

/* source/block_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module block_ram #(
  parameter int RAM_WORDS = 256,
  parameter int BURST_LEN = 4
) (
  input  logic                    clk_core,
  input  logic                    rst,
  input  logic                    cvalid,
  input  logic                    cmd,
  input  soc_bus_pkg::word_addr_t addr,
  input  logic                    wvalid,
  input  soc_bus_pkg::bus_data_t  wdata,
  input  soc_bus_pkg::byte_mask_t wmask,
  input  logic                    wlast,
  input  logic                    rready,
  output logic                    cready,
  output logic                    wready,
  output logic                    rvalid,
  output logic                    rlast,
  output soc_bus_pkg::bus_data_t  rdata
);
  import soc_bus_pkg::*;

  localparam int IDX_W  = $clog2(RAM_WORDS);
  localparam int BEAT_W = $clog2(BURST_LEN);

  bus_data_t         mem [RAM_WORDS];
  logic [IDX_W-1:0]  ptr;
  logic [IDX_W-1:0]  ptr_next;
  logic [IDX_W-1:0]  start;
  // Beat index in the current burst, either direction
  logic [BEAT_W-1:0] beat;
  logic              cmd_xfer;
  logic              rd_xfer;
  logic              wr_xfer;

  assign cready   = !rvalid && !wready;
  assign cmd_xfer = cvalid && cready;
  assign rd_xfer  = rvalid && rready;
  assign wr_xfer  = wvalid && wready;
  assign start    = {addr[IDX_W-1:BEAT_W], {BEAT_W{1'b0}}};
  assign ptr_next = ptr + IDX_W'(1);

  always_ff @(posedge clk_core) begin
    if (rst) begin
      rvalid <= 1'b0;
      rlast  <= 1'b0;
      wready <= 1'b0;
      beat   <= '0;
    end else if (cmd_xfer) begin
      beat  <= '0;
      rlast <= 1'b0;
      if (cmd == CMD_WRITE) begin
        wready <= 1'b1;
      end else begin
        rvalid <= 1'b1;
      end
    end else if (rd_xfer) begin
      rvalid <= !rlast;
      rlast  <= (beat == BEAT_W'(BURST_LEN - 2));
      beat   <= beat + BEAT_W'(1);
    end else if (wr_xfer) begin
      beat <= beat + BEAT_W'(1);
      if (wlast) begin
        wready <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_core) begin
    if (cmd_xfer) begin
      ptr   <= start;
      rdata <= mem[start];
    end else if (rd_xfer && !rlast) begin
      ptr   <= ptr_next;
      rdata <= mem[ptr_next];
    end else if (wr_xfer) begin
      ptr <= ptr_next;
    end
  end

  // Byte lanes written on the accepting edge
  always_ff @(posedge clk_core) begin
    if (wr_xfer) begin
      for (int b = 0; b < 4; b++) begin
        if (wmask[b]) begin
          mem[ptr][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  a_wlast_beat: assert property (@(posedge clk_core) disable iff (rst)
    wr_xfer |-> (wlast == (beat == BEAT_W'(BURST_LEN - 1))));

endmodule

`default_nettype wire

/* source/soc_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_bus #(
  parameter int BURST_LEN = 4,
  parameter int ROM_WORDS = 64,
  parameter int RAM_WORDS = 256
) (
  input  logic                    clk_core,
  input  logic                    rst,
  input  logic                    fe_cvalid,
  input  soc_bus_pkg::word_addr_t fe_addr,
  input  logic                    fe_rready,
  input  logic                    fe_eack,
  output logic                    fe_cready,
  output logic                    fe_rvalid,
  output logic                    fe_error,
  input  logic                    ls_cvalid,
  input  logic                    ls_cmd,
  input  soc_bus_pkg::word_addr_t ls_addr,
  input  logic                    ls_wvalid,
  input  logic                    ls_wlast,
  input  soc_bus_pkg::bus_data_t  ls_wdata,
  input  soc_bus_pkg::byte_mask_t ls_wmask,
  input  logic                    ls_rready,
  input  logic                    ls_eack,
  output logic                    ls_cready,
  output logic                    ls_wready,
  output logic                    ls_rvalid,
  output logic                    ls_error,
  output soc_bus_pkg::bus_data_t  rdata,
  output logic                    rlast
);
  import soc_bus_pkg::*;

  logic       gnt_fetch;
  logic       gnt_mem;
  logic       done;

  // Shared target-side command and write data
  logic       tgt_cmd;
  word_addr_t tgt_addr;
  bus_data_t  tgt_wdata;
  byte_mask_t tgt_wmask;
  logic       tgt_wlast;

  logic       rom_cvalid;
  logic       rom_rready;
  logic       rom_cready;
  logic       rom_rvalid;
  logic       rom_rlast;
  bus_data_t  rom_rdata;

  logic       ram_cvalid;
  logic       ram_wvalid;
  logic       ram_rready;
  logic       ram_cready;
  logic       ram_wready;
  logic       ram_rvalid;
  logic       ram_rlast;
  bus_data_t  ram_rdata;

  bus_arbiter #(
    .BURST_LEN (BURST_LEN)
  ) u_arbiter (
    .clk_core,
    .rst,
    .fe_cvalid,
    .ls_cvalid,
    .done,
    .gnt_fetch,
    .gnt_mem
  );

  bus_main u_bus_main (
    .clk_core,
    .rst,
    .gnt_fetch,
    .gnt_mem,
    .fe_cvalid,
    .fe_addr,
    .fe_rready,
    .fe_eack,
    .ls_cvalid,
    .ls_cmd,
    .ls_addr,
    .ls_wvalid,
    .ls_wlast,
    .ls_wdata,
    .ls_wmask,
    .ls_rready,
    .ls_eack,
    .rom_cready,
    .rom_rvalid,
    .rom_rlast,
    .rom_rdata,
    .ram_cready,
    .ram_wready,
    .ram_rvalid,
    .ram_rlast,
    .ram_rdata,
    .tgt_cmd,
    .tgt_addr,
    .tgt_wdata,
    .tgt_wmask,
    .tgt_wlast,
    .rom_cvalid,
    .rom_rready,
    .ram_cvalid,
    .ram_wvalid,
    .ram_rready,
    .fe_cready,
    .fe_rvalid,
    .fe_error,
    .ls_cready,
    .ls_wready,
    .ls_rvalid,
    .ls_error,
    .rdata,
    .rlast,
    .done
  );

  boot_rom #(
    .ROM_WORDS (ROM_WORDS),
    .BURST_LEN (BURST_LEN)
  ) u_rom (
    .clk_core,
    .rst,
    .cvalid (rom_cvalid),
    .addr   (tgt_addr),
    .rready (rom_rready),
    .cready (rom_cready),
    .rvalid (rom_rvalid),
    .rlast  (rom_rlast),
    .rdata  (rom_rdata)
  );

  block_ram #(
    .RAM_WORDS (RAM_WORDS),
    .BURST_LEN (BURST_LEN)
  ) u_ram (
    .clk_core,
    .rst,
    .cvalid (ram_cvalid),
    .cmd    (tgt_cmd),
    .addr   (tgt_addr),
    .wvalid (ram_wvalid),
    .wdata  (tgt_wdata),
    .wmask  (tgt_wmask),
    .wlast  (tgt_wlast),
    .rready (ram_rready),
    .cready (ram_cready),
    .wready (ram_wready),
    .rvalid (ram_rvalid),
    .rlast  (ram_rlast),
    .rdata  (ram_rdata)
  );

endmodule

`default_nettype wire

/* verif/tb_soc_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc_bus;
  import soc_bus_pkg::*;

  localparam int   BURST_LEN = 4;
  localparam int   ROM_WORDS = 64;
  localparam int   RAM_WORDS = 256;
  localparam int   NUM_ROWS  = 12;
  localparam int   LIMIT     = NUM_ROWS * (BURST_LEN + 8) + 50;
  localparam logic PORT_FE   = 1'b0;
  localparam logic PORT_LS   = 1'b1;

  // Pair flag issues this row and the next in the same cycle
  typedef struct packed {
    logic       port;
    logic       cmd;
    word_addr_t addr;
    byte_mask_t mask;
    logic       stall;
    logic       pair;
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{PORT_FE, CMD_READ,  26'h0000002, 4'hf, 1'b0, 1'b1},
    '{PORT_LS, CMD_WRITE, 26'h0400010, 4'hf, 1'b0, 1'b0},
    '{PORT_LS, CMD_READ,  26'h0400011, 4'hf, 1'b0, 1'b0},
    '{PORT_LS, CMD_WRITE, 26'h0400012, 4'h5, 1'b0, 1'b0},
    '{PORT_LS, CMD_READ,  26'h0400010, 4'hf, 1'b1, 1'b0},
    '{PORT_FE, CMD_READ,  26'h1000000, 4'hf, 1'b0, 1'b0},
    '{PORT_FE, CMD_READ,  26'h000000b, 4'hf, 1'b1, 1'b0},
    '{PORT_LS, CMD_WRITE, 26'h3c00008, 4'hf, 1'b0, 1'b0},
    '{PORT_LS, CMD_WRITE, 26'h0400024, 4'hf, 1'b0, 1'b0},
    '{PORT_FE, CMD_READ,  26'h0000004, 4'hf, 1'b0, 1'b0},
    '{PORT_LS, CMD_READ,  26'h0400027, 4'hf, 1'b0, 1'b1},
    '{PORT_FE, CMD_READ,  26'h000000c, 4'hf, 1'b0, 1'b0}
  };

  logic       clk_core;
  logic       rst;
  logic       fe_cvalid;
  word_addr_t fe_addr;
  logic       fe_rready;
  logic       fe_eack;
  logic       fe_cready;
  logic       fe_rvalid;
  logic       fe_error;
  logic       ls_cvalid;
  logic       ls_cmd;
  word_addr_t ls_addr;
  logic       ls_wvalid;
  logic       ls_wlast;
  bus_data_t  ls_wdata;
  byte_mask_t ls_wmask;
  logic       ls_rready;
  logic       ls_eack;
  logic       ls_cready;
  logic       ls_wready;
  logic       ls_rvalid;
  logic       ls_error;
  bus_data_t  rdata;
  logic       rlast;

  int         errors = 0;
  int         cycles = 0;
  logic [31:0] seed;
  // Model of the arbiter's last-served record
  logic       last_fetch;
  bus_data_t  ref_ram [RAM_WORDS];
  int         first_beat [NUM_ROWS];
  int         last_beat [NUM_ROWS];

  soc_bus #(
    .BURST_LEN (BURST_LEN),
    .ROM_WORDS (ROM_WORDS),
    .RAM_WORDS (RAM_WORDS)
  ) u_soc_bus (
    .clk_core,
    .rst,
    .fe_cvalid,
    .fe_addr,
    .fe_rready,
    .fe_eack,
    .fe_cready,
    .fe_rvalid,
    .fe_error,
    .ls_cvalid,
    .ls_cmd,
    .ls_addr,
    .ls_wvalid,
    .ls_wlast,
    .ls_wdata,
    .ls_wmask,
    .ls_rready,
    .ls_eack,
    .ls_cready,
    .ls_wready,
    .ls_rvalid,
    .ls_error,
    .rdata,
    .rlast
  );

  initial begin
    clk_core = 1'b0;
    forever #20 clk_core = ~clk_core;
  end

  always @(posedge clk_core) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: the bus stopped responding and the run hung after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input string name, input logic [31:0] expv, input logic [31:0] actv);
    if (expv !== actv) begin
      errors++;
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
    end
  endtask

  task automatic drive_cvalid(input logic port, input logic v, input logic cmd,
                              input word_addr_t addr);
    if (port == PORT_LS) begin
      ls_cvalid <= v;
      ls_cmd    <= cmd;
      ls_addr   <= addr;
    end else begin
      fe_cvalid <= v;
      fe_addr   <= addr;
    end
  endtask

  task automatic drive_rready(input logic port, input logic v);
    if (port == PORT_LS) begin
      ls_rready <= v;
    end else begin
      fe_rready <= v;
    end
  endtask

  task automatic drive_eack(input logic port, input logic v);
    if (port == PORT_LS) begin
      ls_eack <= v;
    end else begin
      fe_eack <= v;
    end
  endtask

  task automatic run_txn(input int r);
    row_t       t;
    word_addr_t start;
    logic       mapped;
    logic       got;
    string      pfx;
    bus_data_t  want;
    int         idx;
    int         b;
    int         k;
    t      = ROWS[r];
    pfx    = (t.port == PORT_LS) ? "ls" : "fe";
    start  = t.addr & ~word_addr_t'(BURST_LEN - 1);
    mapped = (t.addr[25:22] == REGION_ROM) || (t.addr[25:22] == REGION_RAM);

    @(posedge clk_core);
    drive_cvalid(t.port, 1'b1, t.cmd, t.addr);
    do begin
      @(negedge clk_core);
      got = (t.port == PORT_LS) ? ls_cready : fe_cready;
    end while (!got);
    @(posedge clk_core);
    drive_cvalid(t.port, 1'b0, t.cmd, t.addr);

    if (!mapped) begin
      // Error level held with no beats until eack
      repeat (2) begin
        @(negedge clk_core);
        check({pfx, "_error"}, 1, 32'((t.port == PORT_LS) ? ls_error : fe_error));
        check({pfx, "_rvalid"}, 0, 32'((t.port == PORT_LS) ? ls_rvalid : fe_rvalid));
      end
      @(posedge clk_core);
      drive_eack(t.port, 1'b1);
      @(posedge clk_core);
      drive_eack(t.port, 1'b0);
      @(negedge clk_core);
      check({pfx, "_error"}, 0, 32'((t.port == PORT_LS) ? ls_error : fe_error));
    end else if (t.cmd == CMD_WRITE) begin
      for (b = 0; b < BURST_LEN; b++) begin
        seed = lcg_step(seed);
        ls_wvalid <= 1'b1;
        ls_wdata  <= seed;
        ls_wmask  <= t.mask;
        ls_wlast  <= (b == BURST_LEN - 1);
        do begin
          @(negedge clk_core);
        end while (!ls_wready);
        if (b == 0) begin
          first_beat[r] = cycles;
        end
        last_beat[r] = cycles;
        idx = (int'(start) + b) % RAM_WORDS;
        for (k = 0; k < 4; k++) begin
          if (t.mask[k]) begin
            ref_ram[idx][8*k +: 8] = seed[8*k +: 8];
          end
        end
        @(posedge clk_core);
      end
      ls_wvalid <= 1'b0;
      ls_wlast  <= 1'b0;
    end else begin
      drive_rready(t.port, 1'b1);
      for (b = 0; b < BURST_LEN; b++) begin
        if (t.addr[25:22] == REGION_ROM) begin
          want = 32'hc0de0000 + ((int'(start) + b) % ROM_WORDS);
        end else begin
          want = ref_ram[(int'(start) + b) % RAM_WORDS];
        end
        if (t.stall && b == 2) begin
          drive_rready(t.port, 1'b0);
          repeat (3) begin
            @(negedge clk_core);
            check({pfx, "_rvalid"}, 1, 32'((t.port == PORT_LS) ? ls_rvalid : fe_rvalid));
            check("rdata", want, rdata);
            check("rlast", 32'(b == BURST_LEN - 1), 32'(rlast));
            @(posedge clk_core);
          end
          drive_rready(t.port, 1'b1);
        end
        do begin
          @(negedge clk_core);
          got = (t.port == PORT_LS) ? ls_rvalid : fe_rvalid;
        end while (!got);
        if (b == 0) begin
          first_beat[r] = cycles;
        end
        last_beat[r] = cycles;
        check("rdata", want, rdata);
        check("rlast", 32'(b == BURST_LEN - 1), 32'(rlast));
        @(posedge clk_core);
      end
      drive_rready(t.port, 1'b0);
    end
    last_fetch = (t.port == PORT_FE);
  endtask

  initial begin
    int r;
    int fe_row;
    int ls_row;
    int win;
    int lose;
    rst        = 1'b1;
    fe_cvalid  = 1'b0;
    fe_addr    = '0;
    fe_rready  = 1'b0;
    fe_eack    = 1'b0;
    ls_cvalid  = 1'b0;
    ls_cmd     = CMD_READ;
    ls_addr    = '0;
    ls_wvalid  = 1'b0;
    ls_wlast   = 1'b0;
    ls_wdata   = '0;
    ls_wmask   = '0;
    ls_rready  = 1'b0;
    ls_eack    = 1'b0;
    seed       = 32'h02a830e6;
    last_fetch = 1'b0;

    @(posedge clk_core);
    @(negedge clk_core);
    check("handshake outputs in reset", 0,
          32'({fe_cready, ls_cready, ls_wready, fe_rvalid, ls_rvalid, fe_error, ls_error}));
    @(posedge clk_core);
    rst <= 1'b0;

    r = 0;
    while (r < NUM_ROWS) begin
      if (ROWS[r].pair) begin
        fe_row = (ROWS[r].port == PORT_FE) ? r : r + 1;
        ls_row = (ROWS[r].port == PORT_FE) ? r + 1 : r;
        // Tie goes to the port not served last
        win    = last_fetch ? ls_row : fe_row;
        lose   = last_fetch ? fe_row : ls_row;
        fork
          run_txn(r);
          run_txn(r + 1);
        join
        check("grant order", 1, 32'(last_beat[win] < first_beat[lose]));
        r = r + 2;
      end else begin
        run_txn(r);
        r = r + 1;
      end
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
source/soc_bus_pkg.sv
source/bus_arbiter.sv
source/bus_main.sv
source/boot_rom.sv
source/block_ram.sv
source/soc_bus.sv
verif/tb_soc_bus.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_soc_bus -o sim_tb_soc_bus &&
./obj_dir/sim_tb_soc_bus | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* rom.hex */
// Boot ROM, one 32-bit hex word per line, word i holds c0de0000 plus i
c0de0000
c0de0001
c0de0002
c0de0003
c0de0004
c0de0005
c0de0006
c0de0007
c0de0008
c0de0009
c0de000a
c0de000b
c0de000c
c0de000d
c0de000e
c0de000f
